// File: axi_slave_mux.f
hw/axi_mux_pkg.sv
hw/axi_write_router.sv
hw/axi_read_router.sv
hw/axi_slave_mux.sv
test/tb_axi_slave_mux.sv

// File: hw/axi_mux_pkg.sv
/*
 * AXI slave mux shared types
 */
package axi_mux_pkg;

    // ----------------------------------------
    // bus widths
    // ----------------------------------------
    localparam int ADDR_W = 64;
    localparam int ID_W   = 32;
    localparam int DATA_W = 64;
    localparam int USER_W = 8;
    // AXI BRESP/RRESP code
    localparam int RESP_W = 2;

    // ----------------------------------------
    // vector types
    // ----------------------------------------
    typedef logic [ADDR_W-1:0] axi_addr_t;
    typedef logic [ID_W-1:0]   axi_id_t;
    typedef logic [DATA_W-1:0] axi_data_t;
    typedef logic [USER_W-1:0] axi_user_t;
    typedef logic [RESP_W-1:0] axi_resp_t;

    // ----------------------------------------
    // write path
    // ----------------------------------------

    // master to slave levels, steered by the write select
    typedef struct packed {
        logic awvalid;
        logic wvalid;
        logic bready;
    } wr_req_t;

    // slave to master, AW/W ready plus the B channel
    typedef struct packed {
        logic      awready;
        logic      wready;
        axi_id_t   bid;
        axi_resp_t bresp;
        axi_user_t buser;
        logic      bvalid;
    } wr_rsp_t;

    // ----------------------------------------
    // read path
    // ----------------------------------------

    // master to slave levels, steered by the read select
    typedef struct packed {
        logic arvalid;
        logic rready;
    } rd_req_t;

    // slave to master, AR ready plus the R channel
    typedef struct packed {
        logic      arready;
        axi_id_t   rid;
        axi_data_t rdata;
        axi_resp_t rresp;
        logic      rlast;
        axi_user_t ruser;
        logic      rvalid;
    } rd_rsp_t;

endpackage

// File: hw/axi_read_router.sv
/*
 * AXI read path router
 */
`timescale 1ns/100ps

module axi_read_router #(
    parameter int NUM_SLAVES = 8
) (
    input  logic                                  ACLK,
    input  logic                                  ARESETn,

    // master side
    input  axi_mux_pkg::axi_addr_t                ar_addr,
    input  axi_mux_pkg::rd_req_t                  m_rd_req,
    output axi_mux_pkg::rd_rsp_t                  m_rd_rsp,

    // slave side
    output axi_mux_pkg::rd_req_t [NUM_SLAVES-1:0] s_rd_req,
    input  axi_mux_pkg::rd_rsp_t [NUM_SLAVES-1:0] s_rd_rsp
);

    // select width from the slave count, at least one bit
    localparam int SEL_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

    typedef logic [SEL_W-1:0] sel_t;

    // slave index taken from the top address bits
    sel_t rd_sel;
    sel_t ar_sel;

    assign ar_sel = ar_addr[axi_mux_pkg::ADDR_W-1 -: SEL_W];

    // ----------------------------------------
    // read select register
    // ----------------------------------------

    // loads on every edge with arvalid high,
    // holds while arvalid is low whatever ar_addr does
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            rd_sel <= '0;
        end else if (m_rd_req.arvalid) begin
            rd_sel <= ar_sel;
        end
    end

    // ----------------------------------------
    // request steering
    // ----------------------------------------

    // arvalid and rready reach the selected slave only
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (rd_sel == sel_t'(i)) begin
                s_rd_req[i] = m_rd_req;
            end else begin
                s_rd_req[i] = '0;
            end
        end
    end

    // ----------------------------------------
    // response return
    // ----------------------------------------

    // arready and the R channel of the selected slave,
    // zero for a select past the last slave
    always_comb begin
        m_rd_rsp = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (rd_sel == sel_t'(i)) begin
                m_rd_rsp = s_rd_rsp[i];
            end
        end
    end

endmodule

// File: hw/axi_slave_mux.sv
/*
 * AXI single master to multi slave mux
 */
`timescale 1ns/100ps

// write and read paths are steered independently,
// each by its own select register inside its router
module axi_slave_mux #(
    parameter int NUM_SLAVES = 8
) (
    input  logic                                  ACLK,
    input  logic                                  ARESETn,

    // ----------------------------------------
    // master side
    // ----------------------------------------
    input  axi_mux_pkg::axi_addr_t                aw_addr,
    input  axi_mux_pkg::axi_addr_t                ar_addr,
    input  axi_mux_pkg::wr_req_t                  m_wr_req,
    input  axi_mux_pkg::rd_req_t                  m_rd_req,
    output axi_mux_pkg::wr_rsp_t                  m_wr_rsp,
    output axi_mux_pkg::rd_rsp_t                  m_rd_rsp,

    // ----------------------------------------
    // slave side
    // ----------------------------------------
    output axi_mux_pkg::wr_req_t [NUM_SLAVES-1:0] s_wr_req,
    output axi_mux_pkg::rd_req_t [NUM_SLAVES-1:0] s_rd_req,
    input  axi_mux_pkg::wr_rsp_t [NUM_SLAVES-1:0] s_wr_rsp,
    input  axi_mux_pkg::rd_rsp_t [NUM_SLAVES-1:0] s_rd_rsp
);

    // ----------------------------------------
    // write path
    // ----------------------------------------

    // AW, W and B channels, select loaded on awvalid
    axi_write_router #(
        .NUM_SLAVES (NUM_SLAVES)
    ) axi_write_router_i (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .aw_addr  (aw_addr),
        .m_wr_req (m_wr_req),
        .m_wr_rsp (m_wr_rsp),
        .s_wr_req (s_wr_req),
        .s_wr_rsp (s_wr_rsp)
    );

    // ----------------------------------------
    // read path
    // ----------------------------------------

    // AR and R channels, select loaded on arvalid
    axi_read_router #(
        .NUM_SLAVES (NUM_SLAVES)
    ) axi_read_router_i (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .ar_addr  (ar_addr),
        .m_rd_req (m_rd_req),
        .m_rd_rsp (m_rd_rsp),
        .s_rd_req (s_rd_req),
        .s_rd_rsp (s_rd_rsp)
    );

endmodule

// File: hw/axi_write_router.sv
/*
 * AXI write path router
 */
`timescale 1ns/100ps

module axi_write_router #(
    parameter int NUM_SLAVES = 8
) (
    input  logic                                  ACLK,
    input  logic                                  ARESETn,

    // master side
    input  axi_mux_pkg::axi_addr_t                aw_addr,
    input  axi_mux_pkg::wr_req_t                  m_wr_req,
    output axi_mux_pkg::wr_rsp_t                  m_wr_rsp,

    // slave side
    output axi_mux_pkg::wr_req_t [NUM_SLAVES-1:0] s_wr_req,
    input  axi_mux_pkg::wr_rsp_t [NUM_SLAVES-1:0] s_wr_rsp
);

    // select width from the slave count, at least one bit
    localparam int SEL_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

    typedef logic [SEL_W-1:0] sel_t;

    // slave index taken from the top address bits
    sel_t wr_sel;
    sel_t aw_sel;

    assign aw_sel = aw_addr[axi_mux_pkg::ADDR_W-1 -: SEL_W];

    // ----------------------------------------
    // write select register
    // ----------------------------------------

    // loads on every edge with awvalid high, so the
    // new target only routes from the next cycle on
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wr_sel <= '0;
        end else if (m_wr_req.awvalid) begin
            wr_sel <= aw_sel;
        end
    end

    // ----------------------------------------
    // request steering
    // ----------------------------------------

    // awvalid, wvalid and bready reach the selected slave only
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (wr_sel == sel_t'(i)) begin
                s_wr_req[i] = m_wr_req;
            end else begin
                s_wr_req[i] = '0;
            end
        end
    end

    // ----------------------------------------
    // response return
    // ----------------------------------------

    // selected slave back to the master,
    // zero when the select points past the last slave
    always_comb begin
        m_wr_rsp = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (wr_sel == sel_t'(i)) begin
                m_wr_rsp = s_wr_rsp[i];
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI slave mux testbench with Verilator.
# Exits non-zero if the build, the run or the result check fails.

ROOT_DIR=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT_DIR" || exit 1

TOP=tb_axi_slave_mux
BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing \
    -f axi_slave_mux.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o sim_bin
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_bin" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^all tests passed$" "$LOG_FILE"; then
    echo "RESULT: PASS"
    exit 0
fi
echo "RESULT: FAIL (see $LOG_FILE)"
exit 1

// File: test/tb_axi_slave_mux.sv
/*
 * AXI slave mux testbench
 */
`timescale 1ns/100ps

module tb_axi_slave_mux;

    localparam int NUM_SLAVES    = 8;
    localparam int SEL_W         = $clog2(NUM_SLAVES);
    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 5;
    localparam int IDLE_CYCLES   = 6;
    localparam int RANDOM_CYCLES = 300;
    localparam int LATCH_ROUNDS  = 10;
    localparam int LATCH_CYCLES  = 4 * LATCH_ROUNDS;
    localparam int SOLO_CYCLES   = 30;
    localparam int MARGIN_CYCLES = 50;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES
                                   + LATCH_CYCLES + 2 * SOLO_CYCLES;
    localparam int WATCHDOG_NS   = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    typedef logic [SEL_W-1:0] sel_t;

    logic                                  ACLK;
    logic                                  ARESETn;
    axi_mux_pkg::axi_addr_t                aw_addr;
    axi_mux_pkg::axi_addr_t                ar_addr;
    axi_mux_pkg::wr_req_t                  m_wr_req;
    axi_mux_pkg::rd_req_t                  m_rd_req;
    axi_mux_pkg::wr_rsp_t                  m_wr_rsp;
    axi_mux_pkg::rd_rsp_t                  m_rd_rsp;
    axi_mux_pkg::wr_req_t [NUM_SLAVES-1:0] s_wr_req;
    axi_mux_pkg::rd_req_t [NUM_SLAVES-1:0] s_rd_req;
    axi_mux_pkg::wr_rsp_t [NUM_SLAVES-1:0] s_wr_rsp;
    axi_mux_pkg::rd_rsp_t [NUM_SLAVES-1:0] s_rd_rsp;

    integer seed = 32'h8bf9_267c;
    int     errors = 0;
    int     checks = 0;

    // model of the two select registers
    sel_t   exp_wr_sel = '0;
    sel_t   exp_rd_sel = '0;

    axi_slave_mux #(
        .NUM_SLAVES (NUM_SLAVES)
    ) axi_slave_mux_i (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .aw_addr  (aw_addr),
        .ar_addr  (ar_addr),
        .m_wr_req (m_wr_req),
        .m_rd_req (m_rd_req),
        .m_wr_rsp (m_wr_rsp),
        .m_rd_rsp (m_rd_rsp),
        .s_wr_req (s_wr_req),
        .s_rd_req (s_rd_req),
        .s_wr_rsp (s_wr_rsp),
        .s_rd_rsp (s_rd_rsp)
    );

    initial begin
        ACLK = 1'b0;
    end

    always #(CLK_PERIOD / 2) ACLK = ~ACLK;

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic logic [127:0] rand_wide();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // any slave index other than the current one
    function automatic sel_t next_target(input sel_t current);
        logic [127:0] rnd;
        rnd = rand_wide();
        return current + (rnd[2:0] % 3'd7) + 3'd1;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic randomize_inputs();
        logic [127:0] rnd;
        rnd = rand_wide();
        aw_addr = rnd[63:0];
        ar_addr = rnd[127:64];
        rnd = rand_wide();
        m_wr_req = rnd[2:0];
        m_rd_req = rnd[4:3];
        for (int i = 0; i < NUM_SLAVES; i++) begin
            rnd = rand_wide();
            s_wr_rsp[i] = rnd[$bits(axi_mux_pkg::wr_rsp_t)-1:0];
            rnd = rand_wide();
            s_rd_rsp[i] = rnd[$bits(axi_mux_pkg::rd_rsp_t)-1:0];
        end
    endtask

    // requests go to the modelled select only and responses come back from it
    task automatic check_outputs(input string phase);
        axi_mux_pkg::wr_req_t [NUM_SLAVES-1:0] exp_s_wr_req;
        axi_mux_pkg::rd_req_t [NUM_SLAVES-1:0] exp_s_rd_req;
        exp_s_wr_req = '0;
        exp_s_rd_req = '0;
        exp_s_wr_req[exp_wr_sel] = m_wr_req;
        exp_s_rd_req[exp_rd_sel] = m_rd_req;
        check_value($sformatf("%s s_wr_req", phase), 128'(exp_s_wr_req), 128'(s_wr_req));
        check_value($sformatf("%s m_wr_rsp", phase), 128'(s_wr_rsp[exp_wr_sel]),
                    128'(m_wr_rsp));
        check_value($sformatf("%s s_rd_req", phase), 128'(exp_s_rd_req), 128'(s_rd_req));
        check_value($sformatf("%s m_rd_rsp", phase), 128'(s_rd_rsp[exp_rd_sel]),
                    128'(m_rd_rsp));
    endtask

    // check late in the cycle then follow the clock edge to the next drive
    task automatic finish_cycle(input string phase);
        #(CLK_PERIOD - 3);
        check_outputs(phase);
        @(posedge ACLK);
        // target is the top three bits of the 64-bit address
        if (m_wr_req.awvalid) begin
            exp_wr_sel = aw_addr[63:61];
        end
        if (m_rd_req.arvalid) begin
            exp_rd_sel = ar_addr[63:61];
        end
        #1;
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    initial begin
        ARESETn  = 1'b0;
        aw_addr  = '0;
        ar_addr  = '0;
        m_wr_req = '0;
        m_rd_req = '0;
        s_wr_rsp = '0;
        s_rd_rsp = '0;
        repeat (RESET_CYCLES) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;

        // slave 0 owns both paths until a valid is seen
        for (int c = 0; c < IDLE_CYCLES; c++) begin
            randomize_inputs();
            m_wr_req.awvalid = 1'b0;
            m_rd_req.arvalid = 1'b0;
            finish_cycle("reset_default");
        end

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            randomize_inputs();
            finish_cycle("random");
        end

        // select holds while valid is low and moves one cycle after the pulse
        for (int r = 0; r < LATCH_ROUNDS; r++) begin
            repeat (2) begin
                randomize_inputs();
                m_wr_req.awvalid = 1'b0;
                m_rd_req.arvalid = 1'b0;
                finish_cycle("latch_hold");
            end
            randomize_inputs();
            m_wr_req.awvalid = 1'b1;
            m_rd_req.arvalid = 1'b1;
            aw_addr[63:61] = next_target(exp_wr_sel);
            ar_addr[63:61] = next_target(exp_rd_sel);
            finish_cycle("latch_pulse");
            randomize_inputs();
            m_wr_req.awvalid = 1'b0;
            m_rd_req.arvalid = 1'b0;
            finish_cycle("latch_after");
        end

        // each select moves only with its own valid
        for (int c = 0; c < SOLO_CYCLES; c++) begin
            randomize_inputs();
            m_wr_req.awvalid = 1'b1;
            m_rd_req.arvalid = 1'b0;
            finish_cycle("write_only");
        end
        for (int c = 0; c < SOLO_CYCLES; c++) begin
            randomize_inputs();
            m_wr_req.awvalid = 1'b0;
            m_rd_req.arvalid = 1'b1;
            finish_cycle("read_only");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // ----------------------------------------
    // watchdog
    // ----------------------------------------

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not complete within %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule
